/* src.f */
+incdir+dv
design/audio_pkg.sv
design/i2s_clock_sync.sv
design/word_fetcher.sv
design/g711_expander.sv
design/sample_player.sv
design/i2s_audio_top.sv
dv/tb_i2s_audio.sv

/* Makefile */
TOP = tb_i2s_audio

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/tb_tests.svh */
// WAV player directed tests with reference G.711 expansion, slot model and result counting

int n_tests = 0;
int n_failed = 0;
int n_errors = 0;
int test_errors = 0; // Errors of the running test

// Reference A-law decoder, code 0x55 gives -8
function automatic logic [15:0] alaw_expand(input logic [7:0] code);
	logic [7:0]  a;
	logic [15:0] t;
	a = code ^ 8'h55;
	t = {8'd0, a[3:0], 4'd0};
	if (a[6:4] == 3'd0)
		t = t + 16'd8;
	else
		t = (t + 16'h108) << (a[6:4] - 3'd1);
	return a[7] ? t : 16'd0 - t; // Sign bit set is positive
endfunction

// Reference mu-law decoder with bias 0x84
function automatic logic [15:0] ulaw_expand(input logic [7:0] code);
	logic [7:0]  u;
	logic [15:0] t;
	u = ~code;
	t = ({9'd0, u[3:0], 3'd0} + 16'h84) << u[6:4];
	return u[7] ? 16'h84 - t : t - 16'h84;
endfunction

// Attenuated sample first, then sign bits to 32
function automatic logic [31:0] slot_word(input logic [15:0] sample);
	logic [15:0] att;
	att = 16'($signed(sample) >>> vol_shift);
	return {att, {16{att[15]}}};
endfunction

task automatic load_header(input logic [15:0] code);
	for (int a = 0; a < mem_words; a++)
		mem[8'(a)] = 16'($urandom);
	mem[0] = audio_pkg::riff_word0;
	mem[1] = audio_pkg::riff_word1;
	mem[8'(audio_pkg::fmt_word_index)] = code;
endtask

// Enable drops, then rises just after a left slot begins
task automatic restart_player();
	@(posedge clk50);
	#1 i2s_enable = 1'b0;
	repeat (10) @(posedge clk50);
	@(negedge i2s_lrclk);
	@(posedge clk50);
	#1;
	i2s_enable = 1'b1;
	slots.delete();
	served.delete();
endtask

task automatic wait_slots(input int n);
	while (slots.size() < n)
		@(posedge clk50);
endtask

task automatic check_format(input string name, input audio_pkg::format_e expected);
	if (play_format !== expected) begin
		$display("** Error %s format: expected %s, actual %s", name, expected.name(),
			play_format.name());
		test_errors++;
	end
endtask

task automatic report_test(input string name);
	n_tests++;
	n_errors += test_errors;
	if (test_errors == 0) begin
		$display("%s: passed", name);
	end else begin
		n_failed++;
		$display("%s: failed with %0d errors", name, test_errors);
	end
	test_errors = 0;
endtask

// Playback is running when enable drops, so every output has something to clear
task automatic disable_hold();
	int bad;
	bad = 0;
	load_header(audio_pkg::code_pcm);
	restart_player();
	wait_slots(4); // First data slots are out
	check_format("disable_hold", audio_pkg::fmt_pcm);
	@(posedge clk50);
	#1 i2s_enable = 1'b0;
	@(posedge clk50); // Registers clear on this edge
	repeat (1100) begin // Over one frame
		@(negedge clk50);
		if (mem_req.rd_en !== 1'b0 || i2s_din !== 1'b0 || play_format !== audio_pkg::fmt_none)
			bad++;
	end
	if (bad != 0) begin
		$display("disable_hold: outputs left the idle state in %0d cycles", bad);
		test_errors++;
	end
	report_test("disable_hold");
endtask

task automatic pcm_playback();
	logic [31:0] exp;
	load_header(audio_pkg::code_pcm);
	restart_player();
	wait_slots(18); // Two silent slots, then 16 words
	check_format("pcm_playback", audio_pkg::fmt_pcm);
	for (int i = 0; i < 18; i++) begin
		exp = (i < 2) ? 32'd0 : slot_word(mem[8'(audio_pkg::data_word_index + i - 2)]);
		if (slots[i] !== exp) begin
			$display("** Error pcm_playback slot %0d: expected 0x%08h, actual 0x%08h", i, exp,
				slots[i]);
			test_errors++;
		end
	end
	if (served.size() < audio_pkg::data_word_index + 16) begin
		$display("pcm_playback: only %0d words were read", served.size());
		test_errors++;
	end
	foreach (served[i]) begin
		if (served[i] !== audio_pkg::addr_t'(i)) begin
			$display("** Error pcm_playback read %0d: expected 0x%0h, actual 0x%0h", i, i,
				served[i]);
			test_errors++;
		end
	end
	report_test("pcm_playback");
endtask

// One word per frame, low byte left and high byte right
task automatic companded_playback(input logic is_ulaw);
	string       name;
	logic [15:0] w;
	logic [31:0] exp;
	name = is_ulaw ? "ulaw_playback" : "alaw_playback";
	load_header(is_ulaw ? audio_pkg::code_ulaw : audio_pkg::code_alaw);
	mem[8'(audio_pkg::data_word_index)] = 16'hd555; // A-law codes for -8 and +8
	restart_player();
	wait_slots(18);
	check_format(name, is_ulaw ? audio_pkg::fmt_ulaw : audio_pkg::fmt_alaw);
	for (int i = 0; i < 18; i++) begin
		w = mem[8'(audio_pkg::data_word_index + (i - 2) / 2)];
		if (i < 2)
			exp = 32'd0; // Header still being read
		else if (i % 2 == 0)
			exp = slot_word(is_ulaw ? ulaw_expand(w[7:0]) : alaw_expand(w[7:0]));
		else
			exp = slot_word(is_ulaw ? ulaw_expand(w[15:8]) : alaw_expand(w[15:8]));
		if (slots[i] !== exp) begin
			$display("** Error %s slot %0d: expected 0x%08h, actual 0x%08h", name, i, exp,
				slots[i]);
			test_errors++;
		end
	end
	report_test(name);
endtask

task automatic header_rejection();
	int high_cnt;
	for (int c = 0; c < 2; c++) begin
		load_header(c == 0 ? audio_pkg::code_pcm : 16'h0011);
		if (c == 0)
			mem[0] = 16'h1234; // Not "RI"
		restart_player();
		high_cnt = 0;
		repeat (3072) begin // Three frames of silence
			@(negedge clk50);
			if (i2s_din !== 1'b0)
				high_cnt++;
		end
		if (high_cnt != 0) begin
			$display("header_rejection case %0d: I2S_DIN was high in %0d cycles", c, high_cnt);
			test_errors++;
		end
		check_format("header_rejection", audio_pkg::fmt_none);
		if (served.size() >= audio_pkg::data_word_index + 3) begin
			$display("header_rejection case %0d: reads went on to %0d words", c, served.size());
			test_errors++;
		end
	end
	report_test("header_rejection");
endtask

/* dv/tb_i2s_audio.sv */
// WAV player testbench with clocks, codec clock source, memory model, slot capture and timeout
`timescale 1ns/1ps

module tb_i2s_audio;

	localparam int vol_shift = 1;          // Attenuation given to the DUT
	localparam int mem_words = 256;
	localparam int timeout_cycles = 200_000; // 12 frames of 1024 cycles per test, wide margin

	logic                    clk50;
	logic                    reset;
	logic                    i2s_enable;
	logic                    i2s_sclk;
	logic                    i2s_lrclk;
	logic                    i2s_din;
	audio_pkg::mem_req_t     mem_req;
	audio_pkg::mem_rsp_t     mem_rsp;
	audio_pkg::format_e      play_format;

	logic [15:0]      mem [mem_words]; // WAV file image, one word per address
	logic [31:0]      slots [$];       // Captured slots, oldest first
	audio_pkg::addr_t served [$];      // Addresses answered by the memory model
	logic [31:0]      shift_reg;
	int               bit_cnt = 0;
	logic             last_lr;
	logic [9:0]       codec_phase;     // Bit 3 is SCLK, bit 9 is LRCLK
	int               cycle_cnt;

	i2s_audio_top #(
		.volume_shift (vol_shift)
	) i_i2s_audio_top (
		.clk50       (clk50),
		.reset       (reset),
		.i2s_enable  (i2s_enable),
		.mem_rsp     (mem_rsp),
		.i2s_sclk    (i2s_sclk),
		.i2s_lrclk   (i2s_lrclk),
		.mem_req     (mem_req),
		.i2s_din     (i2s_din),
		.play_format (play_format)
	);

	initial begin
		clk50 = 1'b0;
		forever #5 clk50 = ~clk50;
	end

	// Codec in master role, SCLK every 8 cycles, LRCLK every 32 SCLK falls
	initial begin
		codec_phase = '0;
		i2s_sclk    = 1'b0;
		i2s_lrclk   = 1'b0;
		forever begin
			@(posedge clk50);
			#1;
			codec_phase = codec_phase + 10'd1;
			i2s_sclk    = codec_phase[3];
			i2s_lrclk   = codec_phase[9]; // Moves together with an SCLK fall
		end
	end

	// Answers each read after 1 to 4 cycles with a one-cycle ack
	initial begin : memory_model
		int lat;
		mem_rsp = '0;
		forever begin
			@(posedge clk50);
			#1;
			mem_rsp.ack = 1'b0;
			if (mem_req.rd_en) begin
				lat = $urandom_range(4, 1);
				repeat (lat - 1) begin
					@(posedge clk50);
					#1;
				end
				if (mem_req.rd_en) begin // Request may vanish when enable drops
					mem_rsp.data = (mem_req.addr[24:8] == '0) ? mem[mem_req.addr[7:0]] : 16'h0000;
					mem_rsp.ack  = 1'b1;
					served.push_back(mem_req.addr);
				end
			end
		end
	end

	// Slot capture on rising SCLK, a new slot starts when LRCLK changes
	always @(posedge i2s_sclk) begin
		if (i2s_lrclk !== last_lr)
			bit_cnt = 0;
		last_lr   = i2s_lrclk;
		shift_reg = {shift_reg[30:0], i2s_din}; // MSB first
		bit_cnt++;
		if (bit_cnt == 32)
			slots.push_back(shift_reg);
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < timeout_cycles) begin
			@(posedge clk50);
			cycle_cnt++;
		end
		$display("Run stopped after %0d cycles, a test never finished", cycle_cnt);
		$display("TB FAILED");
		$finish;
	end

	`include "tb_tests.svh"

	initial begin
		void'($urandom(32'h1676_a7b0));
		reset      = 1'b1;
		i2s_enable = 1'b0;
		repeat (8) @(posedge clk50);
		#1 reset = 1'b0;
		disable_hold();
		pcm_playback();
		companded_playback(1'b0); // A-law
		companded_playback(1'b1); // Mu-law
		header_rejection();
		$display("Tests %0d, failed %0d, errors %0d", n_tests, n_failed, n_errors);
		if (n_failed == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* design/i2s_audio_top.sv */
// WAV player top level, joins the word fetcher, codec clock synchroniser and sample player
`timescale 1ns/1ps

module i2s_audio_top #(
	parameter int volume_shift = 1 // Bits of attenuation, 0 to 4
) (
	input  logic                clk50,
	input  logic                reset,
	input  logic                i2s_enable,
	input  audio_pkg::mem_rsp_t mem_rsp,
	input  logic                i2s_sclk,  // Bit clock from the codec
	input  logic                i2s_lrclk, // Frame clock from the codec
	output audio_pkg::mem_req_t mem_req,
	output logic                i2s_din,
	output audio_pkg::format_e  play_format
);

	audio_pkg::word_stream_t stream;
	audio_pkg::i2s_tick_t    tick;
	logic                    take;

	// Memory side
	word_fetcher i_word_fetcher (
		.clk50   (clk50),
		.reset   (reset),
		.enable  (i2s_enable),
		.mem_rsp (mem_rsp),
		.take    (take),
		.mem_req (mem_req),
		.stream  (stream)
	);

	// Codec clocks into clk50
	i2s_clock_sync i_i2s_clock_sync (
		.clk50     (clk50),
		.reset     (reset),
		.i2s_sclk  (i2s_sclk),
		.i2s_lrclk (i2s_lrclk),
		.tick      (tick)
	);

	sample_player #(
		.volume_shift (volume_shift)
	) i_sample_player (
		.clk50       (clk50),
		.reset       (reset),
		.enable      (i2s_enable),
		.tick        (tick),
		.stream      (stream),
		.take        (take),
		.i2s_din     (i2s_din),
		.play_format (play_format)
	);

endmodule

/* design/sample_player.sv */
// Sample player, checks the WAV header, expands samples and shifts channel slots out on I2S_DIN
`timescale 1ns/1ps

module sample_player #(
	parameter int volume_shift = 1 // Attenuation in bits, 0 to 4
) (
	input  logic                     clk50,
	input  logic                     reset,
	input  logic                     enable,
	input  audio_pkg::i2s_tick_t     tick,
	input  audio_pkg::word_stream_t  stream,
	output logic                     take,
	output logic                     i2s_din,
	output audio_pkg::format_e       play_format
);

	localparam int idx_w = $clog2(audio_pkg::slot_bits);

	typedef enum logic [2:0] {
		hdr_riff,   // Words 0 and 1 must read RIFF
		hdr_skip,   // Header words that are not looked at
		hdr_format, // Word 10 holds the format code
		halt,       // Bad header, silent until enable drops
		wait_frame, // Header done, waiting for a left slot
		play
	} play_state_e;

	play_state_e        state;
	audio_pkg::format_e fmt;
	logic [4:0]         hdr_cnt;     // Header words taken so far
	audio_pkg::word_t   slot_sample; // Attenuated sample of the running slot
	logic [idx_w-1:0]   bit_idx;     // Next bit of the slot
	logic [7:0]         g711_hold;   // Right channel code, high byte of the frame word
	logic               hold_valid;  // Frame word arrived, else right slot is silent

	logic               in_header;
	logic               slot_start;
	logic               is_g711;
	logic               need_word;
	logic [7:0]         g711_code;
	audio_pkg::word_t   g711_sample;
	audio_pkg::word_t   raw_sample;
	audio_pkg::word_t   slot_next;

	assign in_header  = (state == hdr_riff) || (state == hdr_skip) || (state == hdr_format);
	assign slot_start = ((state == wait_frame) && tick.lr_fall) ||
		((state == play) && (tick.lr_fall || tick.lr_rise));
	assign is_g711    = (fmt == audio_pkg::fmt_alaw) || (fmt == audio_pkg::fmt_ulaw);
	assign need_word  = slot_start && (!is_g711 || tick.lr_fall); // G.711 takes once per frame
	assign take       = enable && stream.valid && (in_header || need_word);

	// Left code comes straight off the stream, right from the saved byte
	assign g711_code = tick.lr_fall ? stream.data[7:0] : g711_hold;

	g711_expander i_g711_expander (
		.code    (g711_code),
		.is_ulaw (fmt == audio_pkg::fmt_ulaw),
		.sample  (g711_sample)
	);

	// Underrun gives an all-zero slot
	always_comb begin
		raw_sample = '0;
		if (!is_g711) begin
			if (stream.valid)
				raw_sample = stream.data;
		end else if (tick.lr_fall) begin
			if (stream.valid)
				raw_sample = g711_sample;
		end else if (hold_valid) begin
			raw_sample = g711_sample;
		end
	end

	assign slot_next = $signed(raw_sample) >>> volume_shift; // Keeps the sign on attenuation

	always_ff @(posedge clk50 or posedge reset) begin
		if (reset) begin
			state      <= hdr_riff;
			fmt        <= audio_pkg::fmt_none;
			hdr_cnt    <= '0;
			bit_idx    <= '0;
			hold_valid <= 1'b0;
			i2s_din    <= 1'b0;
		end else if (!enable) begin
			state      <= hdr_riff;
			fmt        <= audio_pkg::fmt_none;
			hdr_cnt    <= '0;
			bit_idx    <= '0;
			hold_valid <= 1'b0;
			i2s_din    <= 1'b0;
		end else begin
			if (in_header && stream.valid)
				hdr_cnt <= hdr_cnt + 1'b1;
			case (state)
				hdr_riff: begin
					if (stream.valid) begin
						if (stream.data != (hdr_cnt[0] ? audio_pkg::riff_word1 :
							audio_pkg::riff_word0))
							state <= halt;
						else if (hdr_cnt[0])
							state <= hdr_skip;
					end
				end
				hdr_skip: begin
					if (stream.valid) begin
						if (hdr_cnt == 5'(audio_pkg::fmt_word_index - 1))
							state <= hdr_format;
						else if (hdr_cnt == 5'(audio_pkg::data_word_index - 1))
							state <= wait_frame; // Last header word taken
					end
				end
				hdr_format: begin
					if (stream.valid) begin
						state <= hdr_skip;
						case (stream.data)
							audio_pkg::code_pcm:  fmt <= audio_pkg::fmt_pcm;
							audio_pkg::code_alaw: fmt <= audio_pkg::fmt_alaw;
							audio_pkg::code_ulaw: fmt <= audio_pkg::fmt_ulaw;
							default:              state <= halt; // Unknown format stays silent
						endcase
					end
				end
				wait_frame: begin
					if (tick.lr_fall)
						state <= play;
				end
				default: ; // Halt and play hold until enable drops
			endcase

			// MSB goes out on the same bit-clock fall that moves LRCLK
			if (slot_start) begin
				i2s_din <= slot_next[audio_pkg::word_w-1];
				bit_idx <= idx_w'(1);
			end else if ((state == play) && tick.sclk_fall) begin
				if (bit_idx >= idx_w'(audio_pkg::word_w))
					i2s_din <= slot_sample[audio_pkg::word_w-1]; // Sign pad to slot end
				else
					i2s_din <= slot_sample[~bit_idx[3:0]]; // Index 15 down to 0
				if (bit_idx != idx_w'(audio_pkg::slot_bits - 1))
					bit_idx <= bit_idx + 1'b1;
			end
			if (slot_start && tick.lr_fall)
				hold_valid <= stream.valid;
		end
	end

	always_ff @(posedge clk50) begin
		if (slot_start)
			slot_sample <= slot_next;
		if (slot_start && tick.lr_fall)
			g711_hold <= stream.data[15:8];
	end

	assign play_format = fmt;

	// Format is settled once audio runs
	a_format_steady: assert property (@(posedge clk50) disable iff (reset)
		(state == play) && enable |=> $stable(play_format));

endmodule

/* design/g711_expander.sv */
// G.711 expander, turns one A-law or mu-law code byte into a 16-bit linear sample
`timescale 1ns/1ps

module g711_expander (
	input  logic              [7:0] code,
	input  logic                    is_ulaw, // Low selects A-law
	output audio_pkg::word_t        sample
);

	logic [7:0]  inv;      // Code with the transmission inversion undone
	logic [2:0]  seg;      // Segment, the exponent
	logic [3:0]  mant;     // Step inside the segment
	logic        negative;
	logic [15:0] mag;      // Magnitude before the sign is applied

	always_comb begin
		// A-law flips every even bit, mu-law flips all of them
		if (is_ulaw)
			inv = ~code;
		else
			inv = code ^ 8'h55;
		seg  = inv[6:4];
		mant = inv[3:0];

		if (is_ulaw) begin
			// Mantissa with half step and bias of 132, scaled by segment, bias removed
			mag      = (16'({1'b1, mant, 3'b100}) << seg) - 16'd132;
			negative = inv[7];
		end else begin
			if (seg == 3'd0)
				mag = 16'({mant, 4'b1000}); // Linear segment, no leading one
			else
				mag = 16'({1'b1, mant, 4'b1000}) << (seg - 3'd1);
			negative = ~inv[7];         // A-law sign bit set means positive
		end

		// Sign magnitude to two's complement
		if (negative)
			sample = 16'd0 - mag;
		else
			sample = mag;
	end

endmodule

/* design/word_fetcher.sv */
// Word fetcher, reads memory words in order over the req/ack bus into a two-word buffer
`timescale 1ns/1ps

module word_fetcher (
	input  logic                     clk50,
	input  logic                     reset,
	input  logic                     enable,
	input  audio_pkg::mem_rsp_t      mem_rsp,
	input  logic                     take,    // Player consumes the head word
	output audio_pkg::mem_req_t      mem_req,
	output audio_pkg::word_stream_t  stream
);

	// Idle, request held until ack, then release until ack drops
	typedef enum logic [1:0] {f_idle, f_request, f_release} fetch_state_e;

	fetch_state_e     state;
	audio_pkg::addr_t addr;      // Next word to read
	audio_pkg::word_t entry [2]; // Buffer storage
	logic             wr_ptr;
	logic             rd_ptr;
	logic [1:0]       count;     // Words held, 0 to 2
	logic             room;
	logic             got_word;

	assign room     = (count < 2'd2);
	assign got_word = (state == f_request) && mem_rsp.ack;

	always_ff @(posedge clk50 or posedge reset) begin
		if (reset) begin
			state  <= f_idle;
			addr   <= '0;
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
		end else if (!enable) begin // Stopped player restarts from word 0
			state  <= f_idle;
			addr   <= '0;
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
		end else begin
			case (state)
				f_idle: begin
					if (room)
						state <= f_request;
				end
				f_request: begin
					if (mem_rsp.ack) begin
						state <= f_release;
						addr  <= addr + 1'b1;
					end
				end
				f_release: begin
					if (!mem_rsp.ack) // Ack must be seen low before the next read
						state <= f_idle;
				end
				default: state <= f_idle;
			endcase
			if (got_word)
				wr_ptr <= ~wr_ptr;
			if (take)
				rd_ptr <= ~rd_ptr;
			case ({got_word, take})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ; // Fill and drain in one cycle cancel
			endcase
		end
	end

	always_ff @(posedge clk50) begin
		if (got_word)
			entry[wr_ptr] <= mem_rsp.data;
	end

	assign mem_req.rd_en = (state == f_request);
	assign mem_req.addr  = addr;
	assign stream.valid  = (count != 2'd0);
	assign stream.data   = entry[rd_ptr];

	// Memory may stall, the address must hold until the ack arrives
	a_addr_hold: assert property (@(posedge clk50) disable iff (reset)
		mem_req.rd_en && !mem_rsp.ack |=> !mem_req.rd_en || $stable(mem_req.addr));

	// Player only pulls a word that is really there
	a_take_valid: assert property (@(posedge clk50) disable iff (reset)
		take |-> stream.valid);

endmodule

/* design/i2s_clock_sync.sv */
// Codec clock synchroniser, brings SCLK and LRCLK into clk50 and decodes their edges into strobes
`timescale 1ns/1ps

module i2s_clock_sync (
	input  logic                  clk50,
	input  logic                  reset,
	input  logic                  i2s_sclk,
	input  logic                  i2s_lrclk,
	output audio_pkg::i2s_tick_t  tick
);

	// Bit 0 follows SCLK, bit 1 follows LRCLK
	logic [1:0] pin_meta; // First stage, may go metastable
	logic [1:0] pin_sync; // Second stage, safe to use
	logic [1:0] pin_prev; // Last settled value for edge compare

	logic sclk_fall;
	logic lr_fall;
	logic lr_rise;

	assign sclk_fall = pin_prev[0] & ~pin_sync[0];
	assign lr_fall   = pin_prev[1] & ~pin_sync[1];
	assign lr_rise   = ~pin_prev[1] & pin_sync[1];

	// Strobes are registered so each lands 3 cycles after the pin edge
	always_ff @(posedge clk50 or posedge reset) begin
		if (reset) begin
			pin_meta <= '0;
			pin_sync <= '0;
			pin_prev <= '0;
			tick     <= '0;
		end else begin
			pin_meta <= {i2s_lrclk, i2s_sclk};
			pin_sync <= pin_meta;
			pin_prev <= pin_sync;
			tick.sclk_fall <= sclk_fall;
			tick.lr_fall   <= lr_fall;  // Frame starts with the left channel
			tick.lr_rise   <= lr_rise;
		end
	end

endmodule

/* design/audio_pkg.sv */
// Audio player shared package with bus widths, stream formats, WAV header constants and bus structs
package audio_pkg;

	localparam int word_w = 16; // Memory word, also one PCM sample
	localparam int addr_w = 25; // Word address, one address per 16 bits

	typedef logic [word_w-1:0] word_t;
	typedef logic [addr_w-1:0] addr_t;

	// Read request toward memory
	typedef struct packed {
		logic  rd_en; // Held high until ack
		addr_t addr;
	} mem_req_t;

	// Memory answer, data only valid with ack
	typedef struct packed {
		logic  ack;
		word_t data;
	} mem_rsp_t;

	// Head of the fetch buffer offered to the player
	typedef struct packed {
		logic  valid;
		word_t data;
	} word_stream_t;

	// Single-cycle codec clock edge strobes in clk50
	typedef struct packed {
		logic sclk_fall;
		logic lr_fall;  // Left slot starts
		logic lr_rise;  // Right slot starts
	} i2s_tick_t;

	typedef enum logic [1:0] {fmt_none, fmt_pcm, fmt_alaw, fmt_ulaw} format_e;

	localparam word_t riff_word0 = 16'h4952; // "RI", little endian
	localparam word_t riff_word1 = 16'h4646; // "FF"
	localparam int fmt_word_index = 10;      // Byte 20 holds the audio format code
	localparam int data_word_index = 22;     // Byte 44, first audio word
	localparam word_t code_pcm = 16'd1;
	localparam word_t code_alaw = 16'd6;
	localparam word_t code_ulaw = 16'd7;
	localparam int slot_bits = 32;           // Bit clocks per channel slot

endpackage
